// File: compile.f
+incdir+rtl
rtl/riscv_isa_pkg.sv
rtl/riscv_ctrl_pkg.sv
rtl/regfile.sv
rtl/decode.sv
rtl/execute.sv
rtl/id_ex_core.sv
tests/tb_id_ex_core.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -f compile.f --top-module tb_id_ex_core \
    -o sim_tb_id_ex_core

./obj_dir/sim_tb_id_ex_core | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "run failed, see sim.log"
    exit 1
fi
echo "run passed"
exit 0

// File: tests/tb_id_ex_core.sv
/* id/ex slice testbench */

`include "riscv_params.svh"

module tb_id_ex_core;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 7;
    localparam int TEST_BUDGET  = 150; // cycles per test, generous

    logic clk_i = 1'b0;
    logic rstn_i = 1'b1;
    riscv_isa_pkg::instr_t     instr_i;
    riscv_isa_pkg::word_t      pc_i, wb_data_i;
    logic                      stall_i, flush_i, wb_we_i;
    riscv_isa_pkg::reg_addr_t  wb_addr_i;
    riscv_ctrl_pkg::id_ex_t    id_ex_o;
    riscv_ctrl_pkg::ex_mem_t   ex_mem_o;

    riscv_isa_pkg::word_t    mregs [32]; // model register file
    riscv_isa_pkg::word_t    lcg_state = 32'hba72;
    riscv_isa_pkg::word_t    pc_cnt = 32'h1000;
    riscv_ctrl_pkg::ex_mem_t cur_exp, exp_s1, exp_s2;
    logic [9:0]              cur_srcs, exp_srcs; // {rs1, rs2} fields
    string                   test_name = "reset";
    int                      err_cnt = 0;
    int                      tests_run = 0;

    id_ex_core DUT (.*);

    initial
    begin
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    function automatic riscv_isa_pkg::word_t rnd();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic riscv_ctrl_pkg::ex_mem_t nop_bundle();
        riscv_ctrl_pkg::ex_mem_t e;
        e = '0;
        e.mem_oper = riscv_ctrl_pkg::MEM_NOP;
        return e;
    endfunction

    // instruction encoders per format
    function automatic riscv_isa_pkg::instr_t enc_r(logic [6:0] f7, logic [4:0] rs2,
            logic [4:0] rs1, logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic riscv_isa_pkg::instr_t enc_i(logic [11:0] imm, logic [4:0] rs1,
            logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic riscv_isa_pkg::instr_t enc_s(logic [11:0] imm, logic [4:0] rs2,
            logic [4:0] rs1, logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], riscv_isa_pkg::STORE};
    endfunction

    function automatic riscv_isa_pkg::instr_t enc_b(logic [12:0] imm, logic [4:0] rs2,
            logic [4:0] rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], riscv_isa_pkg::BRANCH};
    endfunction

    function automatic riscv_isa_pkg::instr_t enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, riscv_isa_pkg::JAL};
    endfunction

    // rv32i integer ops, alt selects sub and sra
    function automatic riscv_isa_pkg::word_t arith(logic [2:0] f3, logic alt,
            riscv_isa_pkg::word_t a, riscv_isa_pkg::word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? riscv_isa_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // expected ex/mem bundle of one instruction
    function automatic riscv_ctrl_pkg::ex_mem_t model(riscv_isa_pkg::instr_t ins,
            riscv_isa_pkg::word_t pc);
        riscv_ctrl_pkg::ex_mem_t e;
        riscv_isa_pkg::word_t a, b, ii, is, ib, iu, ij;
        logic [2:0] f3;
        e  = nop_bundle();
        f3 = ins[14:12];
        a  = mregs[ins[19:15]];
        b  = mregs[ins[24:20]];
        ii = {{20{ins[31]}}, ins[31:20]};
        is = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        ib = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        iu = {ins[31:12], 12'b0};
        ij = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        if (ins == '0)
            return e; // idle slot
        e.store_data = b;
        e.rd_addr    = ins[11:7];
        case (ins[6:0])
            riscv_isa_pkg::LUI, riscv_isa_pkg::AUIPC:
            begin
                e.alu_result    = (ins[5] ? 32'b0 : pc) + iu;
                e.write_rd      = 1'b1;
                e.branch_target = pc + iu;
            end
            riscv_isa_pkg::JAL, riscv_isa_pkg::JALR:
            begin
                e.alu_result    = pc + `PC_INC; // link
                e.write_rd      = 1'b1;
                e.branch_taken  = 1'b1;
                e.branch_target = ins[3] ? pc + ij : (a + ii) & 32'hffff_fffe;
            end
            riscv_isa_pkg::BRANCH:
            begin
                case (f3)
                    3'd0: e.alu_result = {31'b0, a == b};
                    3'd1: e.alu_result = a - b;
                    3'd4: e.alu_result = {31'b0, $signed(a) < $signed(b)};
                    3'd5: e.alu_result = {31'b0, $signed(a) >= $signed(b)};
                    3'd6: e.alu_result = {31'b0, a < b};
                    default: e.alu_result = {31'b0, a >= b};
                endcase
                e.branch_taken  = (e.alu_result != 0);
                e.branch_target = pc + ib;
            end
            riscv_isa_pkg::LOAD:
            begin
                e.alu_result    = a + ii;
                e.mem_oper      = riscv_ctrl_pkg::mem_oper_t'({1'b0, f3});
                e.wb_use_mem    = 1'b1;
                e.write_rd      = 1'b1;
                e.branch_target = pc + ii;
            end
            riscv_isa_pkg::STORE:
            begin
                e.alu_result    = a + is;
                e.mem_oper      = riscv_ctrl_pkg::mem_oper_t'({1'b1, f3});
                e.branch_target = pc + is;
            end
            riscv_isa_pkg::ARITH:
            begin
                e.alu_result    = arith(f3, ins[30], a, b);
                e.write_rd      = 1'b1;
                e.branch_target = pc;
            end
            default: // immediate arithmetic
            begin
                e.alu_result    = arith(f3, f3 == 3'd5 && ins[30], a, ii);
                e.write_rd      = 1'b1;
                e.branch_target = pc + ii;
            end
        endcase
        return e;
    endfunction

    // two-deep expectation pipe, stall holds and flush bubbles
    always @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            exp_s1   <= nop_bundle();
            exp_s2   <= nop_bundle();
            exp_srcs <= '0;
        end
        else
        begin
            exp_s1   <= flush_i ? nop_bundle() : (stall_i ? exp_s1 : cur_exp);
            exp_s2   <= exp_s1;
            exp_srcs <= flush_i ? '0 : (stall_i ? exp_srcs : cur_srcs);
        end
    end

    a_reset_state: assert property (@(posedge clk_i) !rstn_i |->
        (!ex_mem_o.write_rd && ex_mem_o.mem_oper == riscv_ctrl_pkg::MEM_NOP &&
         !ex_mem_o.branch_taken && id_ex_o.bnj_oper == riscv_ctrl_pkg::BNJ_NO))
    else
    begin
        err_cnt++;
        $display("reset state wrong, ex_mem_o or id_ex_o not cleared");
    end

    a_ex_mem: assert property (@(posedge clk_i) disable iff (!rstn_i) ex_mem_o == exp_s2)
    else
    begin
        err_cnt++;
        $display("ERR %s expected %h actual %h", test_name, $sampled(exp_s2),
                 $sampled(ex_mem_o));
    end

    // source addresses for the hazard unit, one edge after issue
    a_id_ex_srcs: assert property (@(posedge clk_i) disable iff (!rstn_i)
        {id_ex_o.rs1_addr, id_ex_o.rs2_addr} == exp_srcs)
    else
    begin
        err_cnt++;
        $display("ERR %s expected %h actual %h", test_name, $sampled(exp_srcs),
                 $sampled({id_ex_o.rs1_addr, id_ex_o.rs2_addr}));
    end

    task automatic issue(riscv_isa_pkg::instr_t ins, logic stall, logic flush);
        @(posedge clk_i);
        instr_i  <= ins;
        pc_i     <= pc_cnt;
        stall_i  <= stall;
        flush_i  <= flush;
        cur_exp  <= model(ins, pc_cnt);
        cur_srcs <= {ins[19:15], ins[24:20]};
        pc_cnt   = pc_cnt + `PC_INC;
    endtask

    task automatic idle(int cycles);
        @(posedge clk_i);
        instr_i  <= '0;
        pc_i     <= '0;
        stall_i  <= 1'b0;
        flush_i  <= 1'b0;
        cur_exp  <= nop_bundle();
        cur_srcs <= '0;
        repeat (cycles) @(posedge clk_i);
    endtask

    task automatic wb_write(int idx, riscv_isa_pkg::word_t val);
        @(posedge clk_i);
        wb_we_i   <= 1'b1;
        wb_addr_i <= idx[4:0];
        wb_data_i <= val;
        if (idx != 0)
            mregs[idx] = val; // x0 stays zero
    endtask

    task automatic finish_test(int errs_before);
        idle(3); // drain both stages
        tests_run++;
        $display("test %s %s, %0d errors", test_name,
                 (err_cnt == errs_before) ? "ok" : "failed", err_cnt - errs_before);
    endtask

    task automatic run_tests();
        riscv_isa_pkg::word_t r;
        logic [2:0] f3;
        int e0;
        e0 = 0; // reset checks count here too
        finish_test(e0);

        test_name = "regs";
        e0 = err_cnt;
        for (int i = 0; i < 32; i++)
            wb_write(i, rnd());
        @(posedge clk_i);
        wb_we_i <= 1'b0;
        issue(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd3, riscv_isa_pkg::ARITH), 1'b0, 1'b0);
        finish_test(e0);

        test_name = "alu";
        e0 = err_cnt;
        for (int i = 0; i < 40; i++)
        begin
            r  = rnd();
            f3 = r[2:0];
            if (r[3])
                issue(enc_r({1'b0, r[4] && (f3 == 0 || f3 == 5), 5'b0}, r[9:5], r[14:10],
                            f3, r[19:15], riscv_isa_pkg::ARITH), 1'b0, 1'b0);
            else if (f3 == 3'd1 || f3 == 3'd5)
                issue(enc_i({1'b0, r[4] && f3 == 5, 5'b0, r[9:5]}, r[14:10], f3, r[19:15],
                            riscv_isa_pkg::ARITH_IMM), 1'b0, 1'b0);
            else
                issue(enc_i(r[31:20], r[14:10], f3, r[19:15], riscv_isa_pkg::ARITH_IMM),
                      1'b0, 1'b0);
        end
        finish_test(e0);

        test_name = "jumps";
        e0 = err_cnt;
        for (int i = 0; i < 8; i++)
        begin
            r = rnd();
            issue({r[31:12], r[11:7], riscv_isa_pkg::LUI}, 1'b0, 1'b0);
            issue({r[31:12], r[11:7], riscv_isa_pkg::AUIPC}, 1'b0, 1'b0);
            issue(enc_j({r[20:1], 1'b0}, r[11:7]), 1'b0, 1'b0);
            issue(enc_i(r[31:20], r[19:15], 3'd0, r[11:7], riscv_isa_pkg::JALR), 1'b0, 1'b0);
        end
        finish_test(e0);

        test_name = "branches";
        e0 = err_cnt;
        for (int i = 0; i < 36; i++)
        begin
            r  = rnd();
            f3 = (i % 6 < 2) ? 3'(i % 6) : 3'(i % 6 + 2);
            // every other round of six compares a register with itself
            issue(enc_b({r[12:1], 1'b0}, ((i / 6) % 2 == 0) ? r[19:15] : r[24:20],
                        r[19:15], f3), 1'b0, 1'b0);
        end
        finish_test(e0);

        test_name = "mem";
        e0 = err_cnt;
        for (int i = 0; i < 15; i++)
        begin
            r  = rnd();
            f3 = (i % 5 < 3) ? 3'(i % 5) : 3'(i % 5 + 1);
            issue(enc_i(r[31:20], r[19:15], f3, r[11:7], riscv_isa_pkg::LOAD), 1'b0, 1'b0);
            issue(enc_s(r[31:20], r[24:20], r[19:15], 3'(i % 3)), 1'b0, 1'b0);
        end
        finish_test(e0);

        test_name = "stall_flush";
        e0 = err_cnt;
        for (int i = 0; i < 4; i++)
        begin
            r = rnd();
            issue(enc_r(7'h20, r[9:5], r[14:10], 3'd0, r[19:15], riscv_isa_pkg::ARITH),
                  1'b0, 1'b0);
            issue(enc_i(r[31:20], r[14:10], 3'd2, r[19:15], riscv_isa_pkg::LOAD), 1'b1, 1'b0);
            issue(enc_j({r[20:1], 1'b0}, r[11:7]), 1'b0, 1'b0);
            issue(enc_s(r[31:20], r[9:5], r[14:10], 3'd2), 1'b0, 1'b1);
            issue(enc_b({r[12:1], 1'b0}, r[9:5], r[14:10], 3'd1), 1'b0, 1'b0);
            issue(enc_i(r[31:20], r[14:10], 3'd0, r[19:15], riscv_isa_pkg::JALR), 1'b1, 1'b1);
        end
        finish_test(e0);
    endtask

    initial
    begin
        instr_i   = '0;
        pc_i      = '0;
        stall_i   = 1'b0;
        flush_i   = 1'b0;
        wb_we_i   = 1'b0;
        wb_addr_i = '0;
        wb_data_i = '0;
        cur_exp   = nop_bundle();
        cur_srcs  = '0;
        for (int i = 0; i < 32; i++)
            mregs[i] = '0;
        #1 rstn_i = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rstn_i <= 1'b1;
        run_tests();
        $display("tests run %0d of %0d, errors %0d", tests_run, NUM_TESTS, err_cnt);
        if (err_cnt == 0 && tests_run == NUM_TESTS)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // watchdog sized from the test count
    initial
    begin
        #((RESET_CYCLES + NUM_TESTS * TEST_BUDGET) * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: rtl/id_ex_core.sv
/* decode and execute slice */

module id_ex_core
(
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  riscv_isa_pkg::instr_t    instr_i,    // from fetch
    input  riscv_isa_pkg::word_t     pc_i,
    input  logic                     stall_i,
    input  logic                     flush_i,
    input  logic                     wb_we_i,    // write-back port
    input  riscv_isa_pkg::reg_addr_t wb_addr_i,
    input  riscv_isa_pkg::word_t     wb_data_i,
    output riscv_ctrl_pkg::id_ex_t   id_ex_o,    // for a hazard unit
    output riscv_ctrl_pkg::ex_mem_t  ex_mem_o
);

    riscv_isa_pkg::reg_addr_t rs1_addr, rs2_addr;
    riscv_isa_pkg::word_t     rs1_data, rs2_data;

    regfile u_regfile (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (wb_we_i),
        .rd_addr_i  (wb_addr_i),
        .rd_data_i  (wb_data_i)
    );

    decode u_decode (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .instr_i         (instr_i),
        .pc_i            (pc_i),
        .regf_rs1_addr_o (rs1_addr),
        .regf_rs2_addr_o (rs2_addr),
        .rs1_data_i      (rs1_data),
        .rs2_data_i      (rs2_data),
        .stall_i         (stall_i),
        .flush_i         (flush_i),
        .id_ex_o         (id_ex_o)
    );

    execute u_execute (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .id_ex_i  (id_ex_o),
        .ex_mem_o (ex_mem_o)
    );

endmodule

// File: rtl/execute.sv
/* execute stage and ex/mem register */

`include "riscv_params.svh"

module execute
(
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  riscv_ctrl_pkg::id_ex_t  id_ex_i,
    output riscv_ctrl_pkg::ex_mem_t ex_mem_o
);

    localparam int SHAMT_W = $clog2(`XLEN_W);

    riscv_isa_pkg::word_t    op1, op2, alu_result, target;
    logic [SHAMT_W-1:0]      shamt;
    logic                    taken;
    riscv_ctrl_pkg::ex_mem_t ex_mem_d;

    always_comb
    begin
        case (id_ex_i.alu_oper1_src)
            riscv_ctrl_pkg::OPER1_PC:   op1 = id_ex_i.pc;
            riscv_ctrl_pkg::OPER1_ZERO: op1 = '0;
            default:                    op1 = id_ex_i.rs1_data;
        endcase
        case (id_ex_i.alu_oper2_src)
            riscv_ctrl_pkg::OPER2_IMM:    op2 = id_ex_i.imm;
            riscv_ctrl_pkg::OPER2_PC_INC: op2 = `PC_INC;
            default:                      op2 = id_ex_i.rs2_data;
        endcase
    end

    assign shamt = op2[SHAMT_W-1:0];

    always_comb
    begin : alu
        case (id_ex_i.alu_oper)
            riscv_ctrl_pkg::ALU_SUB:  alu_result = op1 - op2;
            riscv_ctrl_pkg::ALU_SLL:  alu_result = op1 << shamt;
            riscv_ctrl_pkg::ALU_SRL:  alu_result = op1 >> shamt;
            riscv_ctrl_pkg::ALU_SRA:  alu_result = $signed(op1) >>> shamt;
            riscv_ctrl_pkg::ALU_SLT:  alu_result = riscv_isa_pkg::word_t'($signed(op1) < $signed(op2));
            riscv_ctrl_pkg::ALU_SLTU: alu_result = riscv_isa_pkg::word_t'(op1 < op2);
            riscv_ctrl_pkg::ALU_SEQ:  alu_result = riscv_isa_pkg::word_t'(op1 == op2);
            riscv_ctrl_pkg::ALU_SGE:  alu_result = riscv_isa_pkg::word_t'($signed(op1) >= $signed(op2));
            riscv_ctrl_pkg::ALU_SGEU: alu_result = riscv_isa_pkg::word_t'(op1 >= op2);
            riscv_ctrl_pkg::ALU_XOR:  alu_result = op1 ^ op2;
            riscv_ctrl_pkg::ALU_OR:   alu_result = op1 | op2;
            riscv_ctrl_pkg::ALU_AND:  alu_result = op1 & op2;
            default:                  alu_result = op1 + op2;
        endcase
    end

    // jumps always taken, branches on a nonzero compare
    assign taken = (id_ex_i.bnj_oper == riscv_ctrl_pkg::BNJ_JAL)  ||
                   (id_ex_i.bnj_oper == riscv_ctrl_pkg::BNJ_JALR) ||
                   (id_ex_i.bnj_oper == riscv_ctrl_pkg::BNJ_BRANCH && alu_result != '0);

    assign target = (id_ex_i.bnj_oper == riscv_ctrl_pkg::BNJ_JALR) ?
                    ((id_ex_i.rs1_data + id_ex_i.imm) & ~riscv_isa_pkg::word_t'(1)) :
                    (id_ex_i.pc + id_ex_i.imm);

    assign ex_mem_d = '{alu_result: alu_result, store_data: id_ex_i.rs2_data,
                        mem_oper: id_ex_i.mem_oper, wb_use_mem: id_ex_i.wb_use_mem,
                        write_rd: id_ex_i.write_rd, rd_addr: id_ex_i.rd_addr,
                        branch_taken: taken, branch_target: target};

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            ex_mem_o <= riscv_ctrl_pkg::EX_MEM_NOP;
        else
            ex_mem_o <= ex_mem_d; // no stall, a held id/ex repeats here
    end

    a_no_bnj_not_taken: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (id_ex_i.bnj_oper == riscv_ctrl_pkg::BNJ_NO) |=> !ex_mem_o.branch_taken);

endmodule

// File: rtl/decode.sv
/* instruction decode and id/ex register */

module decode
(
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  riscv_isa_pkg::instr_t    instr_i,
    input  riscv_isa_pkg::word_t     pc_i,
    output riscv_isa_pkg::reg_addr_t regf_rs1_addr_o,
    output riscv_isa_pkg::reg_addr_t regf_rs2_addr_o,
    input  riscv_isa_pkg::word_t     rs1_data_i,
    input  riscv_isa_pkg::word_t     rs2_data_i,
    input  logic                     stall_i,  // hold id/ex
    input  logic                     flush_i,  // load a bubble, wins over stall
    output riscv_ctrl_pkg::id_ex_t   id_ex_o
);

    riscv_isa_pkg::opcode_t    opcode;
    riscv_isa_pkg::reg_addr_t  rs1, rs2, rd;
    riscv_isa_pkg::funct3_t    funct3;
    riscv_isa_pkg::funct7_t    funct7;
    riscv_isa_pkg::word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

    riscv_isa_pkg::word_t           curr_imm;
    riscv_ctrl_pkg::alu_oper1_src_t alu_oper1_src;
    riscv_ctrl_pkg::alu_oper2_src_t alu_oper2_src;
    riscv_ctrl_pkg::bnj_oper_t      bnj_oper;
    riscv_ctrl_pkg::alu_oper_t      alu_oper;
    riscv_ctrl_pkg::mem_oper_t      mem_oper;
    logic                           write_rd;
    logic                           wb_use_mem; // rd takes load data
    riscv_ctrl_pkg::id_ex_t         id_ex_d;

    assign opcode = riscv_isa_pkg::opcode_t'(instr_i[6:0]);
    assign rd     = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];
    assign funct7 = instr_i[31:25];

    // sign-extended immediates per format
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb
    begin : main_decode
        alu_oper1_src = riscv_ctrl_pkg::OPER1_RS1;
        alu_oper2_src = riscv_ctrl_pkg::OPER2_RS2;
        curr_imm      = '0;
        write_rd      = 1'b0;
        wb_use_mem    = 1'b0;
        bnj_oper      = riscv_ctrl_pkg::BNJ_NO;
        mem_oper      = riscv_ctrl_pkg::MEM_NOP;
        case (opcode)
            riscv_isa_pkg::LUI:
            begin
                alu_oper1_src = riscv_ctrl_pkg::OPER1_ZERO;
                alu_oper2_src = riscv_ctrl_pkg::OPER2_IMM;
                curr_imm      = imm_u;
                write_rd      = 1'b1;
            end
            riscv_isa_pkg::AUIPC:
            begin
                alu_oper1_src = riscv_ctrl_pkg::OPER1_PC;
                alu_oper2_src = riscv_ctrl_pkg::OPER2_IMM;
                curr_imm      = imm_u;
                write_rd      = 1'b1;
            end
            riscv_isa_pkg::JAL, riscv_isa_pkg::JALR:
            begin
                alu_oper1_src = riscv_ctrl_pkg::OPER1_PC;      // link address
                alu_oper2_src = riscv_ctrl_pkg::OPER2_PC_INC;
                write_rd      = 1'b1;
                if (opcode == riscv_isa_pkg::JAL)
                begin
                    curr_imm = imm_j;
                    bnj_oper = riscv_ctrl_pkg::BNJ_JAL;
                end
                else
                begin
                    curr_imm = imm_i;
                    bnj_oper = riscv_ctrl_pkg::BNJ_JALR;
                end
            end
            riscv_isa_pkg::BRANCH:
            begin
                curr_imm = imm_b;
                bnj_oper = riscv_ctrl_pkg::BNJ_BRANCH;
            end
            riscv_isa_pkg::LOAD:
            begin
                alu_oper2_src = riscv_ctrl_pkg::OPER2_IMM;
                curr_imm      = imm_i;
                write_rd      = 1'b1;
                wb_use_mem    = 1'b1;
                mem_oper      = riscv_ctrl_pkg::mem_oper_t'({1'b0, funct3});
            end
            riscv_isa_pkg::STORE:
            begin
                alu_oper2_src = riscv_ctrl_pkg::OPER2_IMM;
                curr_imm      = imm_s;
                mem_oper      = riscv_ctrl_pkg::mem_oper_t'({1'b1, funct3});
            end
            riscv_isa_pkg::ARITH: write_rd = 1'b1;
            riscv_isa_pkg::ARITH_IMM:
            begin
                alu_oper2_src = riscv_ctrl_pkg::OPER2_IMM;
                curr_imm      = imm_i;
                write_rd      = 1'b1;
            end
            default: ; // unknown opcode stays a bubble
        endcase
    end

    always_comb
    begin : alu_decode
        alu_oper = riscv_ctrl_pkg::ALU_ADD; // address and link sums
        case (opcode)
            riscv_isa_pkg::BRANCH:
            begin
                if (riscv_isa_pkg::opcode_branch_t'(funct3) == riscv_isa_pkg::BNE)
                    alu_oper = riscv_ctrl_pkg::ALU_SUB; // nonzero when unequal
                else if (riscv_isa_pkg::opcode_branch_t'(funct3) == riscv_isa_pkg::BEQ)
                    alu_oper = riscv_ctrl_pkg::ALU_SEQ;
                else
                    alu_oper = riscv_ctrl_pkg::alu_oper_t'({funct3[0], 1'b0, funct3[2:1]});
            end
            riscv_isa_pkg::ARITH:
                alu_oper = riscv_ctrl_pkg::alu_oper_t'({funct7[5], funct3});
            riscv_isa_pkg::ARITH_IMM:
            begin
                // bit 30 is part of the immediate except on shifts right
                if (riscv_isa_pkg::opcode_alu_t'(funct3) == riscv_isa_pkg::SRA_L)
                    alu_oper = riscv_ctrl_pkg::alu_oper_t'({funct7[5], funct3});
                else
                    alu_oper = riscv_ctrl_pkg::alu_oper_t'({1'b0, funct3});
            end
            default: ;
        endcase
    end

    assign regf_rs1_addr_o = rs1;
    assign regf_rs2_addr_o = rs2;

    always_comb
    begin
        id_ex_d               = riscv_ctrl_pkg::ID_EX_NOP;
        id_ex_d.pc            = pc_i;
        id_ex_d.rs1_data      = rs1_data_i;
        id_ex_d.rs2_data      = rs2_data_i;
        id_ex_d.imm           = curr_imm;
        id_ex_d.alu_oper1_src = alu_oper1_src;
        id_ex_d.alu_oper2_src = alu_oper2_src;
        id_ex_d.bnj_oper      = bnj_oper;
        id_ex_d.alu_oper      = alu_oper;
        id_ex_d.mem_oper      = mem_oper;
        id_ex_d.wb_use_mem    = wb_use_mem;
        id_ex_d.write_rd      = write_rd;
        id_ex_d.rd_addr       = rd;
        id_ex_d.rs1_addr      = rs1;
        id_ex_d.rs2_addr      = rs2;
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            id_ex_o <= riscv_ctrl_pkg::ID_EX_NOP;
        else if (flush_i)
            id_ex_o <= riscv_ctrl_pkg::ID_EX_NOP;
        else if (!stall_i)
            id_ex_o <= id_ex_d;
    end

    a_flush_bubble: assert property (@(posedge clk_i) disable iff (!rstn_i)
        flush_i |=> !id_ex_o.write_rd);

    a_store_no_rd: assert property (@(posedge clk_i) disable iff (!rstn_i)
        id_ex_o.write_rd |-> !(id_ex_o.mem_oper inside
            {riscv_ctrl_pkg::MEM_SB, riscv_ctrl_pkg::MEM_SH, riscv_ctrl_pkg::MEM_SW}));

endmodule

// File: rtl/regfile.sv
/* integer register file */

`include "riscv_params.svh"

module regfile
(
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  riscv_isa_pkg::reg_addr_t rs1_addr_i,
    input  riscv_isa_pkg::reg_addr_t rs2_addr_i,
    output riscv_isa_pkg::word_t     rs1_data_o,
    output riscv_isa_pkg::word_t     rs2_data_o,
    input  logic                     we_i,      // write-back strobe
    input  riscv_isa_pkg::reg_addr_t rd_addr_i,
    input  riscv_isa_pkg::word_t     rd_data_i
);

    localparam int NUM_REGS = 2 ** `REG_ADDR_W;

    riscv_isa_pkg::word_t regs [1:NUM_REGS-1]; // x0 has no storage
    logic wr_en;

    assign wr_en = we_i && (rd_addr_i != '0);

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            for (int i = 1; i < NUM_REGS; i++) regs[i] <= '0;
        else if (wr_en)
            regs[rd_addr_i] <= rd_data_i;
    end

    // write-through of the pending write
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 :
                        (wr_en && rd_addr_i == rs1_addr_i) ? rd_data_i : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 :
                        (wr_en && rd_addr_i == rs2_addr_i) ? rd_data_i : regs[rs2_addr_i];

    a_zero_reg: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ((rs1_addr_i == '0) |-> (rs1_data_o == '0)) and
        ((rs2_addr_i == '0) |-> (rs2_data_o == '0)));

endmodule

// File: rtl/riscv_ctrl_pkg.sv
/* pipeline control types */

package riscv_ctrl_pkg;

    // {instr[30], funct3}, spare codes hold the compare ops
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SEQ  = 4'b1001,
        ALU_SGE  = 4'b1010,
        ALU_SGEU = 4'b1011,
        ALU_SRA  = 4'b1101
    } alu_oper_t;

    typedef enum logic [1:0] {OPER1_RS1, OPER1_PC, OPER1_ZERO} alu_oper1_src_t;
    typedef enum logic [1:0] {OPER2_RS2, OPER2_IMM, OPER2_PC_INC} alu_oper2_src_t;
    typedef enum logic [1:0] {BNJ_NO, BNJ_JAL, BNJ_JALR, BNJ_BRANCH} bnj_oper_t;

    // {store, funct3}
    typedef enum logic [3:0] {
        MEM_LB  = 4'b0000,
        MEM_LH  = 4'b0001,
        MEM_LW  = 4'b0010,
        MEM_LBU = 4'b0100,
        MEM_LHU = 4'b0101,
        MEM_SB  = 4'b1000,
        MEM_SH  = 4'b1001,
        MEM_SW  = 4'b1010,
        MEM_NOP = 4'b1111
    } mem_oper_t;

    typedef struct packed {
        riscv_isa_pkg::word_t     pc;
        riscv_isa_pkg::word_t     rs1_data;
        riscv_isa_pkg::word_t     rs2_data;
        riscv_isa_pkg::word_t     imm;
        alu_oper1_src_t           alu_oper1_src;
        alu_oper2_src_t           alu_oper2_src;
        bnj_oper_t                bnj_oper;
        alu_oper_t                alu_oper;
        mem_oper_t                mem_oper;
        logic                     wb_use_mem;
        logic                     write_rd;
        riscv_isa_pkg::reg_addr_t rd_addr;
        riscv_isa_pkg::reg_addr_t rs1_addr;
        riscv_isa_pkg::reg_addr_t rs2_addr;
    } id_ex_t;

    typedef struct packed {
        riscv_isa_pkg::word_t     alu_result;
        riscv_isa_pkg::word_t     store_data;
        mem_oper_t                mem_oper;
        logic                     wb_use_mem;
        logic                     write_rd;
        riscv_isa_pkg::reg_addr_t rd_addr;
        logic                     branch_taken;
        riscv_isa_pkg::word_t     branch_target;
    } ex_mem_t;

    // bubble contents, also the reset value
    localparam id_ex_t ID_EX_NOP = '{
        alu_oper1_src: OPER1_RS1, alu_oper2_src: OPER2_RS2, bnj_oper: BNJ_NO,
        alu_oper: ALU_ADD, mem_oper: MEM_NOP, default: '0
    };

    localparam ex_mem_t EX_MEM_NOP = '{mem_oper: MEM_NOP, default: '0};

endpackage

// File: rtl/riscv_isa_pkg.sv
/* rv32i instruction encoding */

`include "riscv_params.svh"

package riscv_isa_pkg;

    typedef logic [`XLEN_W-1:0] word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [31:0] instr_t; // fixed by the isa
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        LUI       = 7'b0110111,
        AUIPC     = 7'b0010111,
        JAL       = 7'b1101111,
        JALR      = 7'b1100111,
        BRANCH    = 7'b1100011,
        LOAD      = 7'b0000011,
        STORE     = 7'b0100011,
        ARITH     = 7'b0110011,
        ARITH_IMM = 7'b0010011
    } opcode_t;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } opcode_branch_t;

    // funct3 of register and immediate arithmetic
    typedef enum logic [2:0] {
        ADD_L  = 3'b000,
        SLL_L  = 3'b001,
        SLT_L  = 3'b010,
        SLTU_L = 3'b011,
        XOR_L  = 3'b100,
        SRA_L  = 3'b101, // srl and sra, split by bit 30
        OR_L   = 3'b110,
        AND_L  = 3'b111
    } opcode_alu_t;

endpackage

// File: rtl/riscv_params.svh
/* rv32i core widths */

`ifndef RISCV_PARAMS_SVH
`define RISCV_PARAMS_SVH

// data and pc width
`define XLEN_W 32

// register index width, 32 integer registers
`define REG_ADDR_W 5

// one instruction in bytes
`define PC_INC 4

`endif
